//--- bridgeCommand.sv
`timescale 1ns/1ps

module bridgeCommand #(
  parameter int timeoutLoad = 1000
) (
  input  logic                    clkH,
  input  logic                    reset,
  input  testBridgePkg::rxByte_t  rx,
  input  logic                    hasSpace,
  output testBridgePkg::txByte_t  tx,
  input  logic                    tick1K,
  input  logic [63:0]             dbioMiso,
  output testBridgePkg::dbioReq_t dbio
);

  import testBridgePkg::*;

  localparam int toWidth = $clog2(timeoutLoad + 1);

  localparam int stLen   = 17;
  localparam int stSyncA = 0;
  localparam int stSyncB = 1;
  localparam int stSyncC = 2;
  localparam int stCommA = 3;
  localparam int stCommB = 4;
  localparam int stCommC = 5;
  localparam int stCommD = 6;
  localparam int stMosiA = 7;
  localparam int stMosiB = 8;
  localparam int stMosiC = 9;
  localparam int stMosiD = 10;
  localparam int stMosiE = 11;
  localparam int stMisoA = 12;
  localparam int stMisoB = 13;
  localparam int stMisoC = 14;
  localparam int stMisoD = 15;
  localparam int stMisoE = 16;

  logic [stLen-1:0]   state;
  logic [stLen-1:0]   stateNext;
  ctrlWord_t          ctrl;
  logic [15:0]        dataLen;
  logic [15:0]        dataLenHeld;
  logic [toWidth-1:0] timeout;
  logic [11:0]        addr;
  logic [63:0]        mosi;
  logic [63:0]        misoShift;
  logic [3:0]         mosiIdx;
  logic [3:0]         misoIdx;
  logic               mosi1st;

  logic stateNz;
  logic timeoutNz;
  logic dataLenNz;
  logic recvNow;
  logic isWrite;
  logic isTransfer;
  logic isRead;
  logic mosiStep;
  logic misoStep;
  logic lenRecvL;
  logic lenRecvH;
  logic lenDec;
  logic mosiTake;
  logic timeoutReload;

  assign recvNow   = rx.valid;
  assign stateNz   = |state;
  assign timeoutNz = |timeout;
  assign dataLenNz = |dataLen;

  assign isWrite    = ctrl.fields.opcode == opWrite;
  assign isTransfer = ctrl.fields.opcode == opTransfer;
  assign isRead     = ctrl.fields.opcode == opRead;

  // Points where the remaining length decides the next step
  assign mosiStep = state[stMosiA] | state[stMosiC];
  assign misoStep = state[stMisoB] | state[stMisoD];

  always_comb begin
    stateNext = '0;
    stateNext[stSyncA] = ~stateNz & recvNow & (rx.data == syncByte);
    stateNext[stCommA] = ~stateNz & recvNow & rx.data[7];
    // Sync reply
    stateNext[stSyncB] = state[stSyncA] | (state[stSyncB] & ~hasSpace);
    stateNext[stSyncC] = state[stSyncB] & hasSpace;
    // Header bytes
    stateNext[stCommB] = state[stCommA] | (state[stCommB] & ~recvNow & timeoutNz);
    stateNext[stCommC] = (state[stCommB] & recvNow) |
                         (state[stCommC] & ~recvNow & timeoutNz);
    stateNext[stCommD] = (state[stCommC] & recvNow) |
                         (state[stCommD] & ~recvNow & timeoutNz);
    // Host to chip data
    stateNext[stMosiA] = state[stCommD] & recvNow & (isWrite | isTransfer);
    stateNext[stMosiB] = (mosiStep & dataLenNz) |
                         (state[stMosiB] & ~recvNow & timeoutNz);
    stateNext[stMosiC] = state[stMosiB] & recvNow;
    stateNext[stMosiD] = (mosiStep & ~dataLenNz) | (state[stMosiD] & ~hasSpace);
    stateNext[stMosiE] = state[stMosiD] & hasSpace;
    // Chip to host data
    stateNext[stMisoA] = (state[stCommD] & recvNow & isRead) |
                         (state[stMisoA] & ~hasSpace);
    stateNext[stMisoB] = state[stMisoA] & hasSpace;
    stateNext[stMisoC] = (misoStep & dataLenNz) | (state[stMisoC] & ~hasSpace);
    stateNext[stMisoD] = state[stMisoC] & hasSpace;
    stateNext[stMisoE] = misoStep & ~dataLenNz;
  end

  assign lenRecvL = state[stCommC] & recvNow;
  assign lenRecvH = state[stCommD] & recvNow;
  assign mosiTake = state[stMosiB] & recvNow;
  assign lenDec   = mosiTake | stateNext[stMisoD];

  assign timeoutReload = state[stSyncA] | state[stCommA] | (stateNz & recvNow);

  always_ff @(posedge clkH) begin
    if (reset) begin
      state       <= '0;
      timeout     <= '0;
      dataLen     <= '0;
      dataLenHeld <= '0;
      addr        <= '0;
      mosiIdx     <= '0;
      misoIdx     <= '0;
      mosi1st     <= 1'b0;
    end else begin
      state <= stateNext;

      if (timeoutReload) begin
        timeout <= toWidth'(timeoutLoad);
      end else if (timeoutNz && tick1K) begin
        timeout <= timeout - 1'b1;
      end

      // Length arrives low byte first
      if (lenRecvL) begin
        dataLen     <= {8'h00, rx.data};
        dataLenHeld <= {8'h00, rx.data};
      end else if (lenRecvH) begin
        dataLen     <= {rx.data, dataLen[7:0]};
        dataLenHeld <= {rx.data, dataLenHeld[7:0]};
      end else if (lenDec) begin
        dataLen <= dataLen - 1'b1;
      end

      if (state[stMosiA] || state[stMisoA]) begin
        addr <= ctrl.fields.addr;
      end

      if (state[stMosiA]) begin
        mosiIdx <= '0;
      end else if (mosiTake) begin
        mosiIdx <= mosiIdx + 1'b1;
      end

      if (state[stMisoA]) begin
        misoIdx <= '0;
      end else if (stateNext[stMisoD]) begin
        misoIdx <= misoIdx + 1'b1;
      end

      mosi1st <= state[stMosiA];
    end
  end

  always_ff @(posedge clkH) begin
    if (stateNext[stCommA]) begin
      ctrl.bytes.hi <= rx.data;
    end
    if (state[stCommB] && recvNow) begin
      ctrl.bytes.lo <= rx.data;
    end
    // Lane wraps every eight bytes
    if (mosiTake) begin
      mosi[mosiIdx[2:0]*8 +: 8] <= rx.data;
    end
    if (state[stMisoB]) begin
      misoShift <= dbioMiso;
    end else if (state[stMisoD]) begin
      misoShift <= {8'h00, misoShift[63:8]};
    end
  end

  // Transfer commands complete without an acknowledge
  always_comb begin
    tx.write = state[stSyncC] | (state[stMosiE] & isWrite) |
               state[stMisoB] | state[stMisoD];
    if (state[stSyncC]) begin
      tx.data = syncByte;
    end else if (state[stMisoD]) begin
      tx.data = misoShift[7:0];
    end else begin
      tx.data = ackByte;
    end
  end

  always_comb begin
    dbio.addr      = addr;
    dbio.mosi      = mosi;
    dbio.mosiIdx   = mosiIdx;
    dbio.misoIdx   = misoIdx;
    dbio.mosi1st   = mosi1st;
    dbio.miso1st   = state[stMisoB];
    dbio.dataLen   = dataLenHeld;
    dbio.dataLenNz = dataLenNz;
  end

  stateOneHot: assert property (@(posedge clkH) disable iff (reset)
    $onehot0(state));

endmodule

//--- ftdiPort.sv
`timescale 1ns/1ps

module ftdiPort (
  input  logic                    clkH,
  input  logic                    reset,
  input  testBridgePkg::ftdiIn_t  pinsIn,
  output testBridgePkg::ftdiOut_t pinsOut,
  output testBridgePkg::rxByte_t  rx,
  input  logic [7:0]              head,
  input  logic                    hasData,
  output logic                    rdEn
);

  localparam int stLen   = 4;
  localparam int stRecvA = 0;
  localparam int stRecvB = 1;
  localparam int stSendA = 2;
  localparam int stSendB = 3;

  logic [stLen-1:0] state;
  logic [stLen-1:0] stateNext;
  logic             stateNz;
  logic             rfQ;
  logic             teQ;
  logic [7:0]       recvData;
  logic             busy;
  logic [1:0]       busyHist;
  logic             siwu;

  assign stateNz = |state;

  // Receive has priority over send
  always_comb begin
    stateNext          = '0;
    stateNext[stRecvA] = ~stateNz & rfQ;
    stateNext[stSendA] = ~stateNz & ~rfQ & teQ & hasData;
    stateNext[stRecvB] = state[stRecvA];
    stateNext[stSendB] = state[stSendA];
  end

  assign busy = hasData | state[stSendA] | state[stSendB];

  always_ff @(posedge clkH) begin
    if (reset) begin
      state    <= '0;
      rfQ      <= 1'b0;
      teQ      <= 1'b0;
      busyHist <= 2'b00;
      siwu     <= 1'b0;
    end else begin
      state    <= stateNext;
      rfQ      <= pinsIn.rf;
      teQ      <= pinsIn.te;
      busyHist <= {busyHist[0], busy};
      // Flush once the reply burst has drained
      siwu     <= busyHist == 2'b10;
    end
  end

  // Host data is valid while rd is asserted
  always_ff @(posedge clkH) begin
    if (state[stRecvA]) begin
      recvData <= pinsIn.data;
    end
  end

  assign rdEn = state[stSendB];

  always_comb begin
    rx.valid = state[stRecvB];
    rx.data  = recvData;
  end

  always_comb begin
    pinsOut.data   = head;
    pinsOut.dataOe = state[stSendA] | state[stSendB];
    pinsOut.wr     = state[stSendB];
    pinsOut.rd     = state[stRecvA];
    pinsOut.siwu   = siwu;
  end

  rdWrExclusive: assert property (@(posedge clkH) disable iff (reset)
    !(pinsOut.rd && pinsOut.wr));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbTestBridge -f tb.f -o simTb &&
  ./obj_dir/simTb | tee sim.log &&
  grep -qx "All checks passed" sim.log &&
  echo "Simulation result: PASS" ||
  { echo "Simulation result: FAIL"; exit 1; }

//--- sendFifo.sv
`timescale 1ns/1ps

module sendFifo #(
  parameter int fifoAddrLen = 4
) (
  input  logic                   clkH,
  input  logic                   reset,
  input  testBridgePkg::txByte_t tx,
  input  logic                   rdEn,
  output logic [7:0]             head,
  output logic                   hasData,
  output logic                   hasSpace
);

  localparam int depth = 2 ** fifoAddrLen;

  logic [7:0]             mem [depth];
  logic [fifoAddrLen-1:0] wrPtr;
  logic [fifoAddrLen-1:0] rdPtr;
  logic [fifoAddrLen:0]   count;
  logic                   doWr;
  logic                   doRd;

  assign doWr     = tx.write & hasSpace;
  assign doRd     = rdEn & hasData;
  assign hasData  = count != '0;
  assign hasSpace = count != (fifoAddrLen + 1)'(depth);
  assign head     = mem[rdPtr];

  always_ff @(posedge clkH) begin
    if (doWr) begin
      mem[wrPtr] <= tx.data;
    end
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWr) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRd) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer must wait for space, consumer for data
  noWriteWhenFull: assert property (@(posedge clkH) disable iff (reset)
    tx.write |-> hasSpace);

  noReadWhenEmpty: assert property (@(posedge clkH) disable iff (reset)
    rdEn |-> hasData);

endmodule

//--- tb.f
testBridgePkg.sv
sendFifo.sv
ftdiPort.sv
bridgeCommand.sv
testBridgeFtdi.sv
tbTestBridge.sv

//--- tbTestBridge.sv
`timescale 1ns/1ps

module tbTestBridge;

  import testBridgePkg::*;

  localparam int timeoutTicks = 20;
  localparam int tickEvery    = 5;
  localparam int waitLimit    = 200;

  logic        clkH = 1'b0;
  logic        reset;
  ftdiIn_t     pinsIn;
  ftdiOut_t    pinsOut;
  logic        tick1K = 1'b0;
  logic [63:0] dbioMiso;
  dbioReq_t    dbio;

  logic [31:0] lcgState = 32'h58bb91c5;
  int          tickDiv = 0;
  int          tickCount = 0;
  int          rxCount = 0;
  int          siwuCount = 0;
  int          mosi1stCount = 0;
  int          miso1stCount = 0;
  int          errorCount = 0;
  int          testCount = 0;
  logic        hung = 1'b0;

  // Expected results, changed on the clock edge like the DUT
  logic [7:0]  expBytes [64];
  int          expCount = 0;
  int          expSiwu = 0;
  int          expMosi1st = 0;
  int          expMiso1st = 0;
  logic [11:0] expAddr;
  logic [15:0] expLen;
  logic [63:0] expMosi;
  logic [63:0] expMask;
  logic        checkMosi = 1'b0;
  logic        checkRead = 1'b0;
  logic        endCheck = 1'b0;

  testBridgeFtdi #(
    .fifoAddrLen(4),
    .timeoutLoad(timeoutTicks)
  ) u_dut (
    .clkH     (clkH),
    .reset    (reset),
    .pinsIn   (pinsIn),
    .pinsOut  (pinsOut),
    .tick1K   (tick1K),
    .dbioMiso (dbioMiso),
    .dbio     (dbio)
  );

  always #2 clkH = ~clkH;

  always @(posedge clkH) begin
    tickDiv <= (tickDiv == tickEvery - 1) ? 0 : tickDiv + 1;
    tick1K  <= tickDiv == tickEvery - 1;
  end

  // Host side monitors
  always @(posedge clkH) begin
    if (tick1K) begin
      tickCount <= tickCount + 1;
    end
    if (!reset) begin
      if (pinsOut.wr) begin
        rxCount <= rxCount + 1;
      end
      if (pinsOut.siwu) begin
        siwuCount <= siwuCount + 1;
      end
      if (dbio.mosi1st) begin
        mosi1stCount <= mosi1stCount + 1;
      end
      if (dbio.miso1st) begin
        miso1stCount <= miso1stCount + 1;
      end
    end
  end

  rdWrApart: assert property (@(posedge clkH) disable iff (reset)
    !(pinsOut.rd && pinsOut.wr))
    else begin
      $display("CHECK FAILED at %0t: rd and wr high together", $time);
      errorCount = errorCount + 1;
    end

  dataOeWindow: assert property (@(posedge clkH) disable iff (reset)
    pinsOut.wr |-> pinsOut.dataOe && $past(pinsOut.dataOe) && !$past(pinsOut.wr))
    else begin
      $display("CHECK FAILED at %0t: wr without two cycles of dataOe", $time);
      errorCount = errorCount + 1;
    end

  dataOeThenWr: assert property (@(posedge clkH) disable iff (reset)
    pinsOut.dataOe && !pinsOut.wr |=> pinsOut.wr)
    else begin
      $display("CHECK FAILED at %0t: dataOe not followed by wr", $time);
      errorCount = errorCount + 1;
    end

  replyByte: assert property (@(posedge clkH) disable iff (reset)
    pinsOut.wr |-> (rxCount < expCount) && (pinsOut.data == expBytes[rxCount]))
    else begin
      $display("CHECK FAILED at %0t: reply byte %0d is %h, expected %h", $time,
               rxCount, pinsOut.data, expBytes[rxCount]);
      errorCount = errorCount + 1;
    end

  replyTotal: assert property (@(posedge clkH) disable iff (reset)
    endCheck |-> rxCount == expCount)
    else begin
      $display("CHECK FAILED at %0t: %0d reply bytes, expected %0d", $time,
               rxCount, expCount);
      errorCount = errorCount + 1;
    end

  siwuOnce: assert property (@(posedge clkH) disable iff (reset)
    endCheck |-> siwuCount == expSiwu)
    else begin
      $display("CHECK FAILED at %0t: %0d siwu pulses, expected %0d", $time,
               siwuCount, expSiwu);
      errorCount = errorCount + 1;
    end

  siwuShort: assert property (@(posedge clkH) disable iff (reset)
    pinsOut.siwu |=> !pinsOut.siwu)
    else begin
      $display("CHECK FAILED at %0t: siwu longer than one cycle", $time);
      errorCount = errorCount + 1;
    end

  firstPulses: assert property (@(posedge clkH) disable iff (reset)
    endCheck |-> mosi1stCount == expMosi1st && miso1stCount == expMiso1st)
    else begin
      $display("CHECK FAILED at %0t: mosi1st %0d miso1st %0d, expected %0d %0d",
               $time, mosi1stCount, miso1stCount, expMosi1st, expMiso1st);
      errorCount = errorCount + 1;
    end

  mosiFields: assert property (@(posedge clkH) disable iff (reset)
    endCheck && checkMosi |-> dbio.addr == expAddr && dbio.dataLen == expLen &&
      (dbio.mosi & expMask) == expMosi && dbio.mosiIdx == expLen[3:0] &&
      !dbio.dataLenNz)
    else begin
      $display("CHECK FAILED at %0t: addr %h len %0d idx %0d lenNz %b mosi %h, expected %h %0d %h",
               $time, dbio.addr, dbio.dataLen, dbio.mosiIdx, dbio.dataLenNz,
               dbio.mosi & expMask, expAddr, expLen, expMosi);
      errorCount = errorCount + 1;
    end

  readFields: assert property (@(posedge clkH) disable iff (reset)
    endCheck && checkRead |-> !dbio.dataLenNz && dbio.dataLen == expLen &&
      dbio.addr == expAddr && dbio.misoIdx == expLen[3:0])
    else begin
      $display("CHECK FAILED at %0t: read addr %h len %0d idx %0d lenNz %b, expected %h %0d",
               $time, dbio.addr, dbio.dataLen, dbio.misoIdx, dbio.dataLenNz,
               expAddr, expLen);
      errorCount = errorCount + 1;
    end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic giveUp(input string what);
    $display("Timed out waiting for %s at %0t", what, $time);
    hung = 1'b1;
    forever @(posedge clkH);
  endtask

  // Host holds rf until the port strobes rd
  task automatic hostSend(input logic [7:0] value);
    int cycles;
    cycles = 0;
    @(posedge clkH);
    pinsIn.rf   <= 1'b1;
    pinsIn.data <= value;
    do begin
      @(posedge clkH);
      cycles++;
    end while (!pinsOut.rd && cycles < waitLimit);
    if (!pinsOut.rd) begin
      giveUp("rd from the port");
    end
    pinsIn.rf <= 1'b0;
  endtask

  task automatic awaitReplies();
    int cycles;
    cycles = 0;
    while ((rxCount < expCount || siwuCount < expSiwu) && cycles < waitLimit) begin
      @(posedge clkH);
      cycles++;
    end
    if (rxCount < expCount) begin
      giveUp("the reply bytes");
    end
    if (siwuCount < expSiwu) begin
      giveUp("the siwu flush pulse");
    end
    endCheck <= 1'b1;
    @(posedge clkH);
    endCheck <= 1'b0;
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("Test %0d %s finished, errors so far %0d", testCount, name, errorCount);
  endtask

  task automatic syncExchange();
    expBytes[expCount] <= syncByte;
    expCount <= expCount + 1;
    expSiwu  <= expSiwu + 1;
    hostSend(syncByte);
    awaitReplies();
  endtask

  // Requests arrive while earlier replies still wait in the FIFO
  task automatic syncBurst();
    int i;
    for (i = 0; i < 3; i++) begin
      expBytes[expCount + i] = syncByte;
    end
    expCount <= expCount + 3;
    expSiwu  <= expSiwu + 1;
    repeat (3) begin
      hostSend(syncByte);
    end
    awaitReplies();
  endtask

  task automatic mosiCommand(input logic [3:0] opcode);
    logic [31:0] rnd;
    logic [11:0] addr;
    int          len;
    int          i;
    logic [7:0]  payload;
    logic [63:0] lanes;
    logic [63:0] mask;
    rnd   = nextRandom();
    addr  = rnd[27:16];
    len   = 1 + int'(rnd[10:8]);
    lanes = '0;
    mask  = '0;
    expMosi1st <= expMosi1st + 1;
    if (opcode == opWrite) begin
      expBytes[expCount] <= ackByte;
      expCount <= expCount + 1;
      expSiwu  <= expSiwu + 1;
    end
    // Control high, control low, length low, length high
    hostSend({opcode, addr[11:8]});
    hostSend(addr[7:0]);
    hostSend(8'(len));
    hostSend(8'h00);
    for (i = 0; i < len; i++) begin
      rnd     = nextRandom();
      payload = rnd[23:16];
      lanes[8*i +: 8] = payload;
      mask[8*i +: 8]  = 8'hFF;
      hostSend(payload);
    end
    expAddr   <= addr;
    expLen    <= 16'(len);
    expMosi   <= lanes;
    expMask   <= mask;
    checkMosi <= 1'b1;
    if (opcode == opWrite) begin
      awaitReplies();
    end else begin
      // No acknowledge, so the sync reply is the only byte
      syncExchange();
    end
    checkMosi <= 1'b0;
  endtask

  task automatic readCommand();
    logic [31:0] rnd;
    logic [11:0] addr;
    int          len;
    int          i;
    logic [63:0] miso;
    rnd  = nextRandom();
    addr = rnd[27:16];
    len  = 1 + int'(rnd[10:8]);
    miso = {nextRandom(), nextRandom()};
    @(posedge clkH);
    dbioMiso <= miso;
    // Header byte, then MISO bytes lowest first
    expBytes[expCount] = ackByte;
    for (i = 0; i < len; i++) begin
      expBytes[expCount + 1 + i] = miso[8*i +: 8];
    end
    expCount   <= expCount + 1 + len;
    expSiwu    <= expSiwu + 1;
    expMiso1st <= expMiso1st + 1;
    expAddr    <= addr;
    expLen     <= 16'(len);
    checkRead  <= 1'b1;
    hostSend({opRead, addr[11:8]});
    hostSend(addr[7:0]);
    hostSend(8'(len));
    hostSend(8'h00);
    awaitReplies();
    checkRead <= 1'b0;
  endtask

  task automatic timeoutCase();
    int startTicks;
    int cycles;
    hostSend({opWrite, 4'h3});
    startTicks = tickCount;
    cycles = 0;
    while (tickCount < startTicks + timeoutTicks + 3 && cycles < waitLimit * 4) begin
      @(posedge clkH);
      cycles++;
    end
    if (tickCount < startTicks + timeoutTicks + 3) begin
      giveUp("the command timeout ticks");
    end
    syncExchange();
  endtask

  initial begin
    wait (hung);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset       <= 1'b1;
    pinsIn.rf   <= 1'b0;
    pinsIn.te   <= 1'b1;
    pinsIn.data <= 8'h00;
    dbioMiso    <= '0;
    repeat (2) @(posedge clkH);
    reset <= 1'b0;
    syncExchange();
    reportTest("sync");
    syncBurst();
    reportTest("sync burst");
    repeat (3) begin
      mosiCommand(opWrite);
      reportTest("write");
    end
    repeat (2) begin
      mosiCommand(opTransfer);
      reportTest("transfer");
    end
    repeat (3) begin
      readCommand();
      reportTest("read");
    end
    timeoutCase();
    reportTest("timeout");
    // Let the last assertion actions land
    @(posedge clkH);
    $display("Tests run: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- testBridgeFtdi.sv
`timescale 1ns/1ps

module testBridgeFtdi #(
  parameter int fifoAddrLen = 4,
  parameter int timeoutLoad = 1000
) (
  input  logic                    clkH,
  input  logic                    reset,
  input  testBridgePkg::ftdiIn_t  pinsIn,
  output testBridgePkg::ftdiOut_t pinsOut,
  input  logic                    tick1K,
  input  logic [63:0]             dbioMiso,
  output testBridgePkg::dbioReq_t dbio
);

  import testBridgePkg::*;

  rxByte_t    rx;
  txByte_t    tx;
  logic [7:0] head;
  logic       hasData;
  logic       hasSpace;
  logic       rdEn;

  bridgeCommand #(
    .timeoutLoad(timeoutLoad)
  ) uCommand (
    .clkH     (clkH),
    .reset    (reset),
    .rx       (rx),
    .hasSpace (hasSpace),
    .tx       (tx),
    .tick1K   (tick1K),
    .dbioMiso (dbioMiso),
    .dbio     (dbio)
  );

  // Replies queue here until the host can take them
  sendFifo #(
    .fifoAddrLen(fifoAddrLen)
  ) uSendFifo (
    .clkH     (clkH),
    .reset    (reset),
    .tx       (tx),
    .rdEn     (rdEn),
    .head     (head),
    .hasData  (hasData),
    .hasSpace (hasSpace)
  );

  ftdiPort uPort (
    .clkH    (clkH),
    .reset   (reset),
    .pinsIn  (pinsIn),
    .pinsOut (pinsOut),
    .rx      (rx),
    .head    (head),
    .hasData (hasData),
    .rdEn    (rdEn)
  );

endmodule

//--- testBridgePkg.sv
package testBridgePkg;

  // Reply and request byte values
  localparam logic [7:0] syncByte = 8'h55;
  localparam logic [7:0] ackByte  = 8'h00;

  // Command opcodes, top nibble of the control word
  localparam logic [3:0] opWrite    = 4'hC;
  localparam logic [3:0] opTransfer = 4'hD;
  localparam logic [3:0] opRead     = 4'h8;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } ctrlBytes_t;

  typedef struct packed {
    logic [3:0]  opcode;
    logic [11:0] addr;
  } ctrlFields_t;

  // Filled byte by byte from the bus, decoded as opcode and address
  typedef union packed {
    ctrlBytes_t  bytes;
    ctrlFields_t fields;
  } ctrlWord_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rxByte_t;

  typedef struct packed {
    logic       write;
    logic [7:0] data;
  } txByte_t;

  typedef struct packed {
    logic       rf;
    logic       te;
    logic [7:0] data;
  } ftdiIn_t;

  typedef struct packed {
    logic [7:0] data;
    logic       dataOe;
    logic       wr;
    logic       rd;
    logic       siwu;
  } ftdiOut_t;

  typedef struct packed {
    logic [11:0] addr;
    logic [63:0] mosi;
    logic [3:0]  mosiIdx;
    logic [3:0]  misoIdx;
    logic        mosi1st;
    logic        miso1st;
    logic [15:0] dataLen;
    logic        dataLenNz;
  } dbioReq_t;

endpackage
